// File: common/qp_tx_pkg.sv
package qp_tx_pkg;

    // record and UDP sizes in bytes
    localparam int qp_record_bytes = 64;
    localparam int udp_hdr_bytes = 8;

    // field widths in bits
    localparam int qpn_w = 24;
    localparam int psn_w = 24;
    localparam int key_w = 32;
    localparam int addr_w = 64;
    localparam int ip_w = 32;
    localparam int port_w = 16;

    // byte offsets inside the record, multi-byte fields LSB first
    localparam int off_ctrl = 0;
    localparam int off_loc_qpn = 1;
    localparam int off_loc_psn = 5;
    localparam int off_loc_key = 9;
    localparam int off_loc_base = 13;
    localparam int off_loc_ip = 21;
    localparam int off_rem_qpn = 25;
    localparam int off_rem_psn = 29;
    localparam int off_rem_key = 33;
    localparam int off_rem_base = 37;
    localparam int off_rem_ip = 45;
    localparam int off_listen_port = 49;

    typedef enum logic [2:0] {
        req_connect = 3'd0,
        req_accept  = 3'd1,
        req_close   = 3'd2,
        req_error   = 3'd3,
        req_rsvd_4  = 3'd4,
        req_rsvd_5  = 3'd5,
        req_rsvd_6  = 3'd6,
        req_rsvd_7  = 3'd7
    } qp_req_e;

    typedef enum logic [2:0] {
        ack_ack    = 3'd0,
        ack_nak    = 3'd1,
        ack_rsvd_2 = 3'd2,
        ack_rsvd_3 = 3'd3,
        ack_rsvd_4 = 3'd4,
        ack_rsvd_5 = 3'd5,
        ack_rsvd_6 = 3'd6,
        ack_rsvd_7 = 3'd7
    } qp_ack_e;

    typedef enum logic {
        ser_idle,
        ser_send
    } ser_state_e;

    typedef struct packed {
        logic              valid;
        qp_req_e           req_type;
        logic              ack_valid;
        qp_ack_e           ack_type;
        logic [qpn_w-1:0]  loc_qpn;
        logic [psn_w-1:0]  loc_psn;
        logic [key_w-1:0]  loc_r_key;
        logic [addr_w-1:0] loc_base_addr;
        logic [ip_w-1:0]   loc_ip_addr;
        logic [qpn_w-1:0]  rem_qpn;
        logic [psn_w-1:0]  rem_psn;
        logic [key_w-1:0]  rem_r_key;
        logic [addr_w-1:0] rem_base_addr;
        logic [ip_w-1:0]   rem_ip_addr;
        logic [port_w-1:0] listen_port;
    } qp_record_t;

endpackage

// File: common/payload_if.sv
`timescale 1ns/10ps

// internal payload beat stream, serializer to output stage
interface payload_if #(
    parameter int data_width = 256
);

    logic [data_width-1:0]   tdata;
    logic [data_width/8-1:0] tkeep;
    logic                    tvalid;
    logic                    tlast;
    // registered ready from the output stage
    logic                    accept;

    modport source (
        output tdata, tkeep, tvalid, tlast,
        input  accept
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast,
        output accept
    );

endinterface

// File: hw/qp_record_capture.sv
`timescale 1ns/10ps

module qp_record_capture
    import qp_tx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // record input
    input  logic              s_qp_valid,
    output logic              s_qp_ready,
    input  qp_req_e           req_type,
    input  logic              ack_valid,
    input  qp_ack_e           ack_type,
    input  logic [qpn_w-1:0]  loc_qpn,
    input  logic [psn_w-1:0]  loc_psn,
    input  logic [key_w-1:0]  loc_r_key,
    input  logic [addr_w-1:0] loc_base_addr,
    input  logic [ip_w-1:0]   loc_ip_addr,
    input  logic [qpn_w-1:0]  rem_qpn,
    input  logic [psn_w-1:0]  rem_psn,
    input  logic [key_w-1:0]  rem_r_key,
    input  logic [addr_w-1:0] rem_base_addr,
    input  logic [ip_w-1:0]   rem_ip_addr,
    input  logic [port_w-1:0] udp_dest_port,
    input  logic [port_w-1:0] cfg_source_port,

    // UDP header port
    output logic              hdr_valid,
    input  logic              hdr_ready,
    output logic [ip_w-1:0]   source_ip,
    output logic [ip_w-1:0]   dest_ip,
    output logic [port_w-1:0] source_port,
    output logic [port_w-1:0] dest_port,
    output logic [15:0]       udp_length,

    // to and from the serializer
    input  logic              sending,
    output logic              start,
    output qp_record_t        record
);

    logic accept_rec;
    logic hdr_valid_next;

    assign accept_rec = s_qp_valid && s_qp_ready;

    // header stays up until taken, a new record reloads it
    always_comb begin
        hdr_valid_next = hdr_valid && !hdr_ready;
        if (accept_rec) begin
            hdr_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_qp_ready <= 1'b0;
            hdr_valid <= 1'b0;
            start <= 1'b0;
        end else begin
            // next record only once header is gone and payload is done
            s_qp_ready <= !hdr_valid_next && !sending;
            hdr_valid <= hdr_valid_next;
            start <= accept_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rec) begin
            record.valid <= 1'b1;
            record.req_type <= req_type;
            record.ack_valid <= ack_valid;
            record.ack_type <= ack_type;
            record.loc_qpn <= loc_qpn;
            record.loc_psn <= loc_psn;
            record.loc_r_key <= loc_r_key;
            record.loc_base_addr <= loc_base_addr;
            record.loc_ip_addr <= loc_ip_addr;
            record.rem_qpn <= rem_qpn;
            record.rem_psn <= rem_psn;
            record.rem_r_key <= rem_r_key;
            record.rem_base_addr <= rem_base_addr;
            record.rem_ip_addr <= rem_ip_addr;
            // we advertise our own port as the listening port
            record.listen_port <= cfg_source_port;

            source_ip <= loc_ip_addr;
            dest_ip <= rem_ip_addr;
            source_port <= cfg_source_port;
            dest_port <= udp_dest_port;
            udp_length <= 16'(qp_record_bytes + udp_hdr_bytes);
        end
    end

endmodule

// File: hw/qp_record_serializer.sv
`timescale 1ns/10ps

module qp_record_serializer
    import qp_tx_pkg::*;
#(
    parameter int data_width = 256
) (
    input  logic         clk,
    input  logic         rst,

    input  logic         start,
    input  qp_record_t   record,
    output logic         sending,
    output logic         busy,

    payload_if.source    beat
);

    localparam int lanes = data_width / 8;
    localparam int beats = qp_record_bytes / lanes;
    localparam int ptr_w = (beats > 1) ? $clog2(beats) : 1;
    localparam int image_w = qp_record_bytes * 8;

    ser_state_e state;
    ser_state_e state_next;
    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] ptr_next;
    logic [image_w-1:0] image;

    // flat byte image of the record, padding bytes stay zero
    always_comb begin
        image = '0;
        image[off_ctrl*8 +: 8] = {record.ack_type, record.ack_valid,
                                  record.req_type, record.valid};
        image[off_loc_qpn*8 +: qpn_w] = record.loc_qpn;
        image[off_loc_psn*8 +: psn_w] = record.loc_psn;
        image[off_loc_key*8 +: key_w] = record.loc_r_key;
        image[off_loc_base*8 +: addr_w] = record.loc_base_addr;
        image[off_loc_ip*8 +: ip_w] = record.loc_ip_addr;
        image[off_rem_qpn*8 +: qpn_w] = record.rem_qpn;
        image[off_rem_psn*8 +: psn_w] = record.rem_psn;
        image[off_rem_key*8 +: key_w] = record.rem_r_key;
        image[off_rem_base*8 +: addr_w] = record.rem_base_addr;
        image[off_rem_ip*8 +: ip_w] = record.rem_ip_addr;
        image[off_listen_port*8 +: port_w] = record.listen_port;
    end

    // byte k lands in lane k mod lanes of beat k div lanes
    assign beat.tdata = image[ptr*data_width +: data_width];
    assign beat.tkeep = {lanes{1'b1}};

    always_comb begin
        state_next = state;
        ptr_next = ptr;
        beat.tvalid = 1'b0;
        beat.tlast = 1'b0;

        case (state)
            ser_idle: begin
                if (start) begin
                    state_next = ser_send;
                    ptr_next = '0;
                end
            end
            ser_send: begin
                // one beat per cycle the output stage can take it
                if (beat.accept) begin
                    beat.tvalid = 1'b1;
                    ptr_next = ptr + 1'b1;
                    if (ptr == ptr_w'(beats - 1)) begin
                        beat.tlast = 1'b1;
                        ptr_next = '0;
                        state_next = ser_idle;
                    end
                end
            end
            default: state_next = ser_idle;
        endcase
    end

    // look-ahead level so capture never sees a gap after start
    assign sending = (state_next == ser_send);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ser_idle;
            ptr <= '0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            ptr <= ptr_next;
            busy <= sending;
        end
    end

endmodule

// File: hw/payload_skid_stage.sv
`timescale 1ns/10ps

module payload_skid_stage #(
    parameter int data_width = 256
) (
    input  logic                    clk,
    input  logic                    rst,

    payload_if.sink                 beat,

    output logic [data_width-1:0]   tdata,
    output logic [data_width/8-1:0] tkeep,
    output logic                    tvalid,
    input  logic                    tready,
    output logic                    tlast
);

    logic [data_width-1:0]   temp_tdata;
    logic [data_width/8-1:0] temp_tkeep;
    logic                    temp_tlast;
    logic                    temp_valid;

    logic tvalid_next;
    logic temp_valid_next;
    logic accept_early;
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // room next cycle if the sink drains or both registers are empty
    assign accept_early = tready || (!temp_valid && !tvalid);

    always_comb begin
        tvalid_next = tvalid;
        temp_valid_next = temp_valid;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (beat.accept) begin
            if (tready || !tvalid) begin
                tvalid_next = beat.tvalid;
                in_to_out = 1'b1;
            end else begin
                // output stalled, park the incoming beat
                temp_valid_next = beat.tvalid;
                in_to_temp = 1'b1;
            end
        end else if (tready) begin
            tvalid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tvalid <= 1'b0;
            temp_valid <= 1'b0;
            beat.accept <= 1'b0;
        end else begin
            tvalid <= tvalid_next;
            temp_valid <= temp_valid_next;
            beat.accept <= accept_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            tdata <= beat.tdata;
            tkeep <= beat.tkeep;
            tlast <= beat.tlast;
        end else if (temp_to_out) begin
            tdata <= temp_tdata;
            tkeep <= temp_tkeep;
            tlast <= temp_tlast;
        end

        if (in_to_temp) begin
            temp_tdata <= beat.tdata;
            temp_tkeep <= beat.tkeep;
            temp_tlast <= beat.tlast;
        end
    end

endmodule

// File: hw/qp_conn_tx.sv
`timescale 1ns/10ps

// RoCE connection manager, transmit side over UDP
module qp_conn_tx
    import qp_tx_pkg::*;
#(
    parameter int data_width = 256
) (
    input  logic                    clk,
    input  logic                    rst,

    // queue-pair record
    input  logic                    s_qp_valid,
    output logic                    s_qp_ready,
    input  qp_req_e                 req_type,
    input  logic                    ack_valid,
    input  qp_ack_e                 ack_type,
    input  logic [qpn_w-1:0]        loc_qpn,
    input  logic [psn_w-1:0]        loc_psn,
    input  logic [key_w-1:0]        loc_r_key,
    input  logic [addr_w-1:0]       loc_base_addr,
    input  logic [ip_w-1:0]         loc_ip_addr,
    input  logic [qpn_w-1:0]        rem_qpn,
    input  logic [psn_w-1:0]        rem_psn,
    input  logic [key_w-1:0]        rem_r_key,
    input  logic [addr_w-1:0]       rem_base_addr,
    input  logic [ip_w-1:0]         rem_ip_addr,
    input  logic [port_w-1:0]       udp_dest_port,

    // UDP header
    output logic                    hdr_valid,
    input  logic                    hdr_ready,
    output logic [ip_w-1:0]         source_ip,
    output logic [ip_w-1:0]         dest_ip,
    output logic [port_w-1:0]       source_port,
    output logic [port_w-1:0]       dest_port,
    output logic [15:0]             udp_length,

    // UDP payload
    output logic [data_width-1:0]   tdata,
    output logic [data_width/8-1:0] tkeep,
    output logic                    tvalid,
    input  logic                    tready,
    output logic                    tlast,

    output logic                    busy,
    input  logic [port_w-1:0]       cfg_source_port
);

    logic       start;
    logic       sending;
    qp_record_t record;

    payload_if #(.data_width(data_width)) beat_if ();

    qp_record_capture u_capture (
        .clk             (clk),
        .rst             (rst),
        .s_qp_valid      (s_qp_valid),
        .s_qp_ready      (s_qp_ready),
        .req_type        (req_type),
        .ack_valid       (ack_valid),
        .ack_type        (ack_type),
        .loc_qpn         (loc_qpn),
        .loc_psn         (loc_psn),
        .loc_r_key       (loc_r_key),
        .loc_base_addr   (loc_base_addr),
        .loc_ip_addr     (loc_ip_addr),
        .rem_qpn         (rem_qpn),
        .rem_psn         (rem_psn),
        .rem_r_key       (rem_r_key),
        .rem_base_addr   (rem_base_addr),
        .rem_ip_addr     (rem_ip_addr),
        .udp_dest_port   (udp_dest_port),
        .cfg_source_port (cfg_source_port),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .source_ip       (source_ip),
        .dest_ip         (dest_ip),
        .source_port     (source_port),
        .dest_port       (dest_port),
        .udp_length      (udp_length),
        .sending         (sending),
        .start           (start),
        .record          (record)
    );

    qp_record_serializer #(.data_width(data_width)) u_serializer (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .record  (record),
        .sending (sending),
        .busy    (busy),
        .beat    (beat_if.source)
    );

    payload_skid_stage #(.data_width(data_width)) u_skid (
        .clk    (clk),
        .rst    (rst),
        .beat   (beat_if.sink),
        .tdata  (tdata),
        .tkeep  (tkeep),
        .tvalid (tvalid),
        .tready (tready),
        .tlast  (tlast)
    );

endmodule

// File: test/qp_conn_tx_checker.sv
`timescale 1ns/10ps

// protocol checks on the top-level ports of qp_conn_tx
module qp_conn_tx_checker #(
    parameter int data_width = 256
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  s_qp_ready,
    input logic                  hdr_valid,
    input logic                  hdr_ready,
    input logic [data_width-1:0] tdata,
    input logic                  tvalid,
    input logic                  tready,
    input logic                  tlast,
    input logic                  busy
);

    // failures seen so far, read by the testbench at the end
    int assert_fails = 0;

    // output register clears in reset
    assert property (@(posedge clk) rst |=> !tvalid)
        else begin
            $error("tvalid high after reset");
            assert_fails++;
        end

    // payload held while the sink stalls
    assert property (@(posedge clk) disable iff (rst)
        (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tlast)))
        else begin
            $error("payload changed while stalled");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (rst)
        (hdr_valid && !hdr_ready) |=> hdr_valid)
        else begin
            $error("hdr_valid dropped before the header was taken");
            assert_fails++;
        end

    // no new record while the payload is still going out
    assert property (@(posedge clk) disable iff (rst) busy |-> !s_qp_ready)
        else begin
            $error("s_qp_ready high while busy");
            assert_fails++;
        end

endmodule

bind qp_conn_tx qp_conn_tx_checker #(.data_width(data_width)) u_checker (
    .clk        (clk),
    .rst        (rst),
    .s_qp_ready (s_qp_ready),
    .hdr_valid  (hdr_valid),
    .hdr_ready  (hdr_ready),
    .tdata      (tdata),
    .tvalid     (tvalid),
    .tready     (tready),
    .tlast      (tlast),
    .busy       (busy)
);

// File: test/qp_conn_tx_tb.sv
`timescale 1ns/10ps

module qp_conn_tx_tb
    import qp_tx_pkg::*;
();

    localparam int data_width = 256;
    localparam int lanes = data_width / 8;
    localparam int beats = 64 / lanes;

    logic                    clk;
    logic                    rst;
    logic                    s_qp_valid;
    logic                    s_qp_ready;
    qp_req_e                 req_type;
    logic                    ack_valid;
    qp_ack_e                 ack_type;
    logic [qpn_w-1:0]        loc_qpn;
    logic [psn_w-1:0]        loc_psn;
    logic [key_w-1:0]        loc_r_key;
    logic [addr_w-1:0]       loc_base_addr;
    logic [ip_w-1:0]         loc_ip_addr;
    logic [qpn_w-1:0]        rem_qpn;
    logic [psn_w-1:0]        rem_psn;
    logic [key_w-1:0]        rem_r_key;
    logic [addr_w-1:0]       rem_base_addr;
    logic [ip_w-1:0]         rem_ip_addr;
    logic [port_w-1:0]       udp_dest_port;
    logic                    hdr_valid;
    logic                    hdr_ready;
    logic [ip_w-1:0]         source_ip;
    logic [ip_w-1:0]         dest_ip;
    logic [port_w-1:0]       source_port;
    logic [port_w-1:0]       dest_port;
    logic [15:0]             udp_length;
    logic [data_width-1:0]   tdata;
    logic [data_width/8-1:0] tkeep;
    logic                    tvalid;
    logic                    tready;
    logic                    tlast;
    logic                    busy;
    logic [port_w-1:0]       cfg_source_port;

    logic [15:0] lfsr;
    logic [7:0]  exp_bytes [64];
    int          errors;
    int          tests_run;
    int          tests_failed;

    qp_conn_tx #(.data_width(data_width)) u_qp_conn_tx (.*);

    always #2 clk = ~clk;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // multi-byte fields go in least significant byte first
    task automatic put_field(input int off, input int nbytes, input logic [63:0] value);
        for (int i = 0; i < nbytes; i++) begin
            exp_bytes[off + i] = value[8*i +: 8];
        end
    endtask

    // random record on the inputs plus its expected 64-byte image
    task automatic make_record();
        logic [63:0] v;
        rand_bits(3, v);
        req_type = qp_req_e'(v[2:0]);
        rand_bits(1, v);
        ack_valid = v[0];
        rand_bits(3, v);
        ack_type = qp_ack_e'(v[2:0]);
        rand_bits(qpn_w, v);
        loc_qpn = v[qpn_w-1:0];
        rand_bits(psn_w, v);
        loc_psn = v[psn_w-1:0];
        rand_bits(key_w, v);
        loc_r_key = v[key_w-1:0];
        rand_bits(addr_w, v);
        loc_base_addr = v;
        rand_bits(ip_w, v);
        loc_ip_addr = v[ip_w-1:0];
        rand_bits(qpn_w, v);
        rem_qpn = v[qpn_w-1:0];
        rand_bits(psn_w, v);
        rem_psn = v[psn_w-1:0];
        rand_bits(key_w, v);
        rem_r_key = v[key_w-1:0];
        rand_bits(addr_w, v);
        rem_base_addr = v;
        rand_bits(ip_w, v);
        rem_ip_addr = v[ip_w-1:0];
        rand_bits(port_w, v);
        udp_dest_port = v[port_w-1:0];

        foreach (exp_bytes[i]) begin
            exp_bytes[i] = 8'h00;
        end
        exp_bytes[off_ctrl] = {ack_type, ack_valid, req_type, 1'b1};
        put_field(off_loc_qpn, 3, 64'(loc_qpn));
        put_field(off_loc_psn, 3, 64'(loc_psn));
        put_field(off_loc_key, 4, 64'(loc_r_key));
        put_field(off_loc_base, 8, loc_base_addr);
        put_field(off_loc_ip, 4, 64'(loc_ip_addr));
        put_field(off_rem_qpn, 3, 64'(rem_qpn));
        put_field(off_rem_psn, 3, 64'(rem_psn));
        put_field(off_rem_key, 4, 64'(rem_r_key));
        put_field(off_rem_base, 8, rem_base_addr);
        put_field(off_rem_ip, 4, 64'(rem_ip_addr));
        put_field(off_listen_port, 2, 64'(cfg_source_port));
    endtask

    // every task starts and ends just after a rising edge
    task automatic send_record();
        int  cyc;
        bit  done;
        cyc = 0;
        done = 1'b0;
        s_qp_valid = 1'b1;
        while (!done && cyc < 100) begin
            done = s_qp_ready;
            @(posedge clk);
            #1;
            cyc++;
        end
        s_qp_valid = 1'b0;
        assert (done) else begin
            $display("timeout: record was never accepted");
            errors++;
        end
    endtask

    task automatic check_beat(input int b);
        for (int l = 0; l < lanes; l++) begin
            check_value($sformatf("tdata byte %0d", b*lanes + l),
                        64'(tdata[8*l +: 8]), 64'(exp_bytes[b*lanes + l]));
        end
        check_value("tkeep", 64'(tkeep), 64'({lanes{1'b1}}));
        check_value("tlast", 64'(tlast), 64'(b == beats - 1));
    endtask

    // take one header and one payload; hdr_hold keeps hdr_ready low and
    // offers another record meanwhile
    task automatic collect_packet(input bit stall, input int hdr_hold);
        logic [63:0] v;
        int          cyc;
        int          nbeats;
        bit          hdr_seen;
        bit          busy_seen;
        cyc = 0;
        nbeats = 0;
        hdr_seen = 1'b0;
        busy_seen = 1'b0;
        while ((!hdr_seen || nbeats < beats) && cyc < 400) begin
            if (stall) begin
                rand_bits(1, v);
                tready = v[0];
            end else begin
                tready = 1'b1;
            end
            hdr_ready = (cyc >= hdr_hold);
            s_qp_valid = (cyc < hdr_hold);
            if (cyc < hdr_hold) begin
                check_value("s_qp_ready", 64'(s_qp_ready), 64'h0);
                check_value("hdr_valid", 64'(hdr_valid), 64'h1);
            end
            if (busy) begin
                busy_seen = 1'b1;
            end
            if (hdr_valid && hdr_ready) begin
                assert (!hdr_seen) else begin
                    $display("a second header came out for one record");
                    errors++;
                end
                check_value("source_ip", 64'(source_ip), 64'(loc_ip_addr));
                check_value("dest_ip", 64'(dest_ip), 64'(rem_ip_addr));
                check_value("source_port", 64'(source_port), 64'(cfg_source_port));
                check_value("dest_port", 64'(dest_port), 64'(udp_dest_port));
                check_value("udp_length", 64'(udp_length), 64'd72);
                hdr_seen = 1'b1;
            end
            if (tvalid && tready) begin
                assert (nbeats < beats) else begin
                    $display("payload has more beats than the record holds");
                    errors++;
                end
                if (nbeats < beats) begin
                    check_beat(nbeats);
                end
                nbeats++;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        s_qp_valid = 1'b0;
        assert (hdr_seen && nbeats == beats) else begin
            $display("timeout: header or payload beats did not arrive");
            errors++;
        end
        assert (busy_seen) else begin
            $display("busy never rose while the record was being sent");
            errors++;
        end
    endtask

    // nothing more may come out after a packet
    task automatic expect_quiet(input int n);
        tready = 1'b1;
        hdr_ready = 1'b1;
        repeat (n) begin
            check_value("tvalid", 64'(tvalid), 64'h0);
            check_value("hdr_valid", 64'(hdr_valid), 64'h0);
            check_value("busy", 64'(busy), 64'h0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - e0);
        end
    endtask

    task automatic after_reset();
        int e0;
        int cyc;
        bit seen;
        e0 = errors;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("s_qp_ready", 64'(s_qp_ready), 64'h0);
        check_value("hdr_valid", 64'(hdr_valid), 64'h0);
        check_value("tvalid", 64'(tvalid), 64'h0);
        check_value("busy", 64'(busy), 64'h0);
        cyc = 0;
        seen = 1'b0;
        while (!seen && cyc < 20) begin
            @(posedge clk);
            #1;
            seen = s_qp_ready;
            cyc++;
        end
        assert (seen) else begin
            $display("timeout: s_qp_ready never rose after reset");
            errors++;
        end
        finish_test("reset", e0);
    endtask

    task automatic single_record();
        int e0;
        e0 = errors;
        make_record();
        send_record();
        collect_packet(1'b0, 0);
        expect_quiet(4);
        finish_test("single record", e0);
    endtask

    task automatic payload_stalls();
        int e0;
        e0 = errors;
        make_record();
        send_record();
        collect_packet(1'b1, 0);
        expect_quiet(8);
        finish_test("payload stalls", e0);
    endtask

    task automatic header_hold();
        int e0;
        e0 = errors;
        make_record();
        send_record();
        collect_packet(1'b0, 24);
        expect_quiet(8);
        finish_test("header hold", e0);
    endtask

    task automatic back_to_back();
        int e0;
        e0 = errors;
        repeat (5) begin
            make_record();
            send_record();
            collect_packet(1'b0, 0);
        end
        expect_quiet(4);
        finish_test("back to back", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        s_qp_valid = 1'b0;
        req_type = req_connect;
        ack_valid = 1'b0;
        ack_type = ack_ack;
        loc_qpn = '0;
        loc_psn = '0;
        loc_r_key = '0;
        loc_base_addr = '0;
        loc_ip_addr = '0;
        rem_qpn = '0;
        rem_psn = '0;
        rem_r_key = '0;
        rem_base_addr = '0;
        rem_ip_addr = '0;
        udp_dest_port = '0;
        hdr_ready = 1'b0;
        tready = 1'b0;
        // RoCEv2 well-known port
        cfg_source_port = 16'h12B7;
        lfsr = 16'd57;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;

        after_reset();
        single_record();
        payload_stalls();
        header_hold();
        back_to_back();

        errors += u_qp_conn_tx.u_checker.assert_fails;
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/qp_tx_pkg.sv
common/payload_if.sv
hw/qp_record_capture.sv
hw/qp_record_serializer.sv
hw/payload_skid_stage.sv
hw/qp_conn_tx.sv
test/qp_conn_tx_checker.sv
test/qp_conn_tx_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module qp_conn_tx_tb -f vlog.f -o qp_conn_tx_sim
	out="$$(./obj_dir/qp_conn_tx_sim +verilator+error+limit+100)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
